/* verilog/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width
`define RV_XLEN 32

// register file size and index width
`define RV_NREGS 32
`define RV_REG_AW 5

// first fetch address
`define RV_RESET_PC 32'h0000_0000

`endif

/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  ////////////////////
  // major opcodes
  ////////////////////
  localparam logic [6:0] OP_ALU    = 7'b0110011;
  localparam logic [6:0] OP_ALUI   = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;

  ////////////////////
  // control encodings
  ////////////////////
  typedef enum logic [1:0] {
    ALU_IN_A_REG,
    ALU_IN_A_PC,
    ALU_IN_A_ZERO
  } alu_in_a_t;

  typedef enum logic {
    ALU_IN_B_REG,
    ALU_IN_B_IMM
  } alu_in_b_t;

  typedef enum logic [1:0] {
    ALU_OP_FROM_F3,
    ALU_OP_FIXED_ADD,
    // branch compare
    ALU_OP_FIXED_SUB
  } alu_mode_t;

  typedef enum logic [1:0] {
    DEST_REG_FROM_NONE,
    DEST_REG_FROM_ALU,
    DEST_REG_FROM_MEM,
    DEST_REG_FROM_PC
  } dest_reg_from_t;

  typedef enum logic [1:0] {
    PC_SRC_NEXT_PC,
    PC_SRC_ALU,
    PC_SRC_BRANCH
  } pc_src_t;

  typedef enum logic [1:0] {
    PH_NULL,
    PH_ADDR_OUT,
    PH_LOAD_IR,
    PH_EXEC
  } phase_t;

  typedef struct packed {
    alu_in_a_t      alu_in_a;
    alu_in_b_t      alu_in_b;
    alu_mode_t      alu_mode;
    dest_reg_from_t dest_reg_from;
    pc_src_t        pc_src;
    logic           pc_load;
    logic           dbus_we;
    logic           dbus_re;
    logic           is_branch;
  } cu_t;

endpackage

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module alu import rv_pkg::*; (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  alu_mode_t           mode,
  input  logic [2:0]          funct3,
  input  logic                funct7_b5,
  input  logic                sub_ok,
  output logic [`RV_XLEN-1:0] y,
  output logic                zero
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (mode)
      ALU_OP_FIXED_ADD: y = a + b;
      ALU_OP_FIXED_SUB: y = a - b;
      default: begin
        case (funct3)
          // SUB only exists in the register form
          3'b000: y = (sub_ok && funct7_b5) ? a - b : a + b;
          3'b001: y = a << shamt;
          3'b010: y = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
          3'b011: y = {{(`RV_XLEN-1){1'b0}}, a < b};
          3'b100: y = a ^ b;
          3'b101: y = funct7_b5 ? $unsigned($signed(a) >>> shamt) : a >> shamt;
          3'b110: y = a | b;
          default: y = a & b;
        endcase
      end
    endcase
  end

  assign zero = (y == '0);

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] ra1,
  input  logic [`RV_REG_AW-1:0] ra2,
  output logic [`RV_XLEN-1:0]   rd1,
  output logic [`RV_XLEN-1:0]   rd2,
  input  logic                  we,
  input  logic [`RV_REG_AW-1:0] wa,
  input  logic [`RV_XLEN-1:0]   wd
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst)
    (ra1 == '0) |-> (rd1 == '0))
    else $error("x0 read back nonzero on port 1");

  a_x0_zero2: assert property (@(posedge clk) disable iff (!rst)
    (ra2 == '0) |-> (rd2 == '0))
    else $error("x0 read back nonzero on port 2");

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module control_unit import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [6:0] opcode,
  input  logic       hold,
  output cu_t        active,
  output logic       load_ir,
  output logic       en_iaddr,
  output logic       exec
);

  ////////////////////
  // decode table
  ////////////////////
  localparam cu_t null_cu = '{
    alu_in_a: ALU_IN_A_REG, alu_in_b: ALU_IN_B_REG, alu_mode: ALU_OP_FROM_F3,
    dest_reg_from: DEST_REG_FROM_NONE, pc_src: PC_SRC_NEXT_PC,
    pc_load: 1'b0, dbus_we: 1'b0, dbus_re: 1'b0, is_branch: 1'b0
  };
  localparam cu_t alu_cu = '{
    alu_in_a: ALU_IN_A_REG, alu_in_b: ALU_IN_B_REG, alu_mode: ALU_OP_FROM_F3,
    dest_reg_from: DEST_REG_FROM_ALU, pc_src: PC_SRC_NEXT_PC,
    pc_load: 1'b0, dbus_we: 1'b0, dbus_re: 1'b0, is_branch: 1'b0
  };
  localparam cu_t aluimm_cu = '{
    alu_in_a: ALU_IN_A_REG, alu_in_b: ALU_IN_B_IMM, alu_mode: ALU_OP_FROM_F3,
    dest_reg_from: DEST_REG_FROM_ALU, pc_src: PC_SRC_NEXT_PC,
    pc_load: 1'b0, dbus_we: 1'b0, dbus_re: 1'b0, is_branch: 1'b0
  };
  localparam cu_t load_cu = '{
    alu_in_a: ALU_IN_A_REG, alu_in_b: ALU_IN_B_IMM, alu_mode: ALU_OP_FIXED_ADD,
    dest_reg_from: DEST_REG_FROM_MEM, pc_src: PC_SRC_NEXT_PC,
    pc_load: 1'b0, dbus_we: 1'b0, dbus_re: 1'b1, is_branch: 1'b0
  };
  localparam cu_t store_cu = '{
    alu_in_a: ALU_IN_A_REG, alu_in_b: ALU_IN_B_IMM, alu_mode: ALU_OP_FIXED_ADD,
    dest_reg_from: DEST_REG_FROM_NONE, pc_src: PC_SRC_NEXT_PC,
    pc_load: 1'b0, dbus_we: 1'b1, dbus_re: 1'b0, is_branch: 1'b0
  };
  // rs1 - rs2 drives the zero flag
  localparam cu_t branch_cu = '{
    alu_in_a: ALU_IN_A_REG, alu_in_b: ALU_IN_B_REG, alu_mode: ALU_OP_FIXED_SUB,
    dest_reg_from: DEST_REG_FROM_NONE, pc_src: PC_SRC_BRANCH,
    pc_load: 1'b1, dbus_we: 1'b0, dbus_re: 1'b0, is_branch: 1'b1
  };
  localparam cu_t jal_cu = '{
    alu_in_a: ALU_IN_A_PC, alu_in_b: ALU_IN_B_IMM, alu_mode: ALU_OP_FIXED_ADD,
    dest_reg_from: DEST_REG_FROM_PC, pc_src: PC_SRC_ALU,
    pc_load: 1'b1, dbus_we: 1'b0, dbus_re: 1'b0, is_branch: 1'b0
  };
  localparam cu_t jalr_cu = '{
    alu_in_a: ALU_IN_A_REG, alu_in_b: ALU_IN_B_IMM, alu_mode: ALU_OP_FIXED_ADD,
    dest_reg_from: DEST_REG_FROM_PC, pc_src: PC_SRC_ALU,
    pc_load: 1'b1, dbus_we: 1'b0, dbus_re: 1'b0, is_branch: 1'b0
  };
  localparam cu_t lui_cu = '{
    alu_in_a: ALU_IN_A_ZERO, alu_in_b: ALU_IN_B_IMM, alu_mode: ALU_OP_FIXED_ADD,
    dest_reg_from: DEST_REG_FROM_ALU, pc_src: PC_SRC_NEXT_PC,
    pc_load: 1'b0, dbus_we: 1'b0, dbus_re: 1'b0, is_branch: 1'b0
  };
  localparam cu_t auipc_cu = '{
    alu_in_a: ALU_IN_A_PC, alu_in_b: ALU_IN_B_IMM, alu_mode: ALU_OP_FIXED_ADD,
    dest_reg_from: DEST_REG_FROM_ALU, pc_src: PC_SRC_NEXT_PC,
    pc_load: 1'b0, dbus_we: 1'b0, dbus_re: 1'b0, is_branch: 1'b0
  };

  phase_t phase, next_phase;

  ////////////////////
  // phase sequencing
  ////////////////////
  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      phase      <= PH_NULL;
      next_phase <= PH_ADDR_OUT;
    end else if (!hold) begin
      phase <= next_phase;
      case (next_phase)
        PH_ADDR_OUT: next_phase <= PH_LOAD_IR;
        PH_LOAD_IR:  next_phase <= PH_EXEC;
        PH_EXEC:     next_phase <= PH_ADDR_OUT;
        default:     next_phase <= PH_NULL;
      endcase
    end
  end

  assign en_iaddr = (phase == PH_ADDR_OUT) || (phase == PH_LOAD_IR);
  assign load_ir  = (phase == PH_LOAD_IR);
  assign exec     = (phase == PH_EXEC);

  always_comb begin
    case (opcode)
      OP_ALU:    active = alu_cu;
      OP_ALUI:   active = aluimm_cu;
      OP_LOAD:   active = load_cu;
      OP_STORE:  active = store_cu;
      OP_BRANCH: active = branch_cu;
      OP_JAL:    active = jal_cu;
      OP_JALR:   active = jalr_cu;
      OP_LUI:    active = lui_cu;
      OP_AUIPC:  active = auipc_cu;
      default:   active = null_cu;
    endcase
  end

  // the instruction fetched during load_ir must decode to a real class
  a_exec_decoded: assert property (@(posedge clk) disable iff (!rst)
    exec |-> (active != null_cu))
    else $error("unknown opcode %07b in exec", opcode);

  a_strobes_excl: assert property (@(posedge clk) disable iff (!rst)
    exec |-> !(active.dbus_we && active.dbus_re))
    else $error("read and write strobes both set");

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module datapath import rv_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                hold,
  input  cu_t                 active,
  input  logic                load_ir,
  input  logic                exec,
  output logic [6:0]          opcode,
  output logic [`RV_XLEN-1:0] iaddr,
  input  logic [`RV_XLEN-1:0] idata,
  output logic [`RV_XLEN-1:0] daddr,
  output logic [`RV_XLEN-1:0] dwdata,
  input  logic [`RV_XLEN-1:0] drdata
);

  logic [`RV_XLEN-1:0] pc, ir, pc_plus4, pc_next, pc_target;
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  logic [`RV_XLEN-1:0] rd1, rd2, alu_a, alu_b, alu_y, wb_data;
  logic                alu_zero, br_taken, redirect, rf_we;

  ////////////////////
  // pc and ir
  ////////////////////
  always_ff @(posedge clk, negedge rst) begin
    if (!rst) begin
      pc <= `RV_RESET_PC;
    end else if (exec && !hold) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (load_ir && !hold) begin
      ir <= idata;
    end
  end

  assign opcode   = ir[6:0];
  assign iaddr    = pc;
  assign pc_plus4 = pc + `RV_XLEN'd4;

  ////////////////////
  // immediates
  ////////////////////
  assign imm_i = {{(`RV_XLEN-12){ir[31]}}, ir[31:20]};
  assign imm_s = {{(`RV_XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{(`RV_XLEN-13){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'h000};
  assign imm_j = {{(`RV_XLEN-21){ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OP_STORE:         imm = imm_s;
      OP_BRANCH:        imm = imm_b;
      OP_LUI, OP_AUIPC: imm = imm_u;
      OP_JAL:           imm = imm_j;
      default:          imm = imm_i;
    endcase
  end

  // operand muxes
  always_comb begin
    case (active.alu_in_a)
      ALU_IN_A_PC:   alu_a = pc;
      ALU_IN_A_ZERO: alu_a = '0;
      default:       alu_a = rd1;
    endcase
  end

  assign alu_b = (active.alu_in_b == ALU_IN_B_IMM) ? imm : rd2;

  reg_file u_reg_file (
    .clk (clk),
    .rst (rst),
    .ra1 (ir[19:15]),
    .ra2 (ir[24:20]),
    .rd1 (rd1),
    .rd2 (rd2),
    .we  (rf_we),
    .wa  (ir[11:7]),
    .wd  (wb_data)
  );

  alu u_alu (
    .a         (alu_a),
    .b         (alu_b),
    .mode      (active.alu_mode),
    .funct3    (ir[14:12]),
    .funct7_b5 (ir[30]),
    .sub_ok    (opcode == OP_ALU),
    .y         (alu_y),
    .zero      (alu_zero)
  );

  ////////////////////
  // next pc
  ////////////////////
  // funct3[0] separates BNE from BEQ
  assign br_taken = active.is_branch && (ir[12] ? !alu_zero : alu_zero);
  assign redirect = active.pc_load && (!active.is_branch || br_taken);

  always_comb begin
    case (active.pc_src)
      PC_SRC_ALU:    pc_target = {alu_y[`RV_XLEN-1:1], 1'b0};
      PC_SRC_BRANCH: pc_target = pc + imm_b;
      default:       pc_target = pc_plus4;
    endcase
  end

  assign pc_next = redirect ? pc_target : pc_plus4;

  // write-back
  always_comb begin
    case (active.dest_reg_from)
      DEST_REG_FROM_MEM: wb_data = drdata;
      DEST_REG_FROM_PC:  wb_data = pc_plus4;
      default:           wb_data = alu_y;
    endcase
  end

  assign rf_we  = exec && !hold && (active.dest_reg_from != DEST_REG_FROM_NONE);
  assign daddr  = alu_y;
  assign dwdata = rd2;

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rv_core import rv_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                hold,
  output logic [`RV_XLEN-1:0] iaddr,
  output logic                en_iaddr,
  input  logic [`RV_XLEN-1:0] idata,
  output logic [`RV_XLEN-1:0] daddr,
  output logic [`RV_XLEN-1:0] dwdata,
  output logic                dbus_we,
  output logic                dbus_re,
  input  logic [`RV_XLEN-1:0] drdata
);

  cu_t        active;
  logic       load_ir, exec;
  logic [6:0] opcode;

  control_unit u_control_unit (
    .clk      (clk),
    .rst      (rst),
    .opcode   (opcode),
    .hold     (hold),
    .active   (active),
    .load_ir  (load_ir),
    .en_iaddr (en_iaddr),
    .exec     (exec)
  );

  datapath u_datapath (
    .clk     (clk),
    .rst     (rst),
    .hold    (hold),
    .active  (active),
    .load_ir (load_ir),
    .exec    (exec),
    .opcode  (opcode),
    .iaddr   (iaddr),
    .idata   (idata),
    .daddr   (daddr),
    .dwdata  (dwdata),
    .drdata  (drdata)
  );

  // strobes only in the exec phase
  assign dbus_we = active.dbus_we && exec;
  assign dbus_re = active.dbus_re && exec;

endmodule

`default_nettype wire

/* bench/tb_memory.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module tb_memory (
  input  logic                clk,
  input  logic                hold,
  input  logic [`RV_XLEN-1:0] iaddr,
  output logic [`RV_XLEN-1:0] idata,
  input  logic [`RV_XLEN-1:0] daddr,
  input  logic [`RV_XLEN-1:0] dwdata,
  input  logic                dbus_we,
  output logic [`RV_XLEN-1:0] drdata
);

  localparam int MEM_WORDS = 256;
  localparam int LOG_DEPTH = 64;

  logic [`RV_XLEN-1:0] imem [MEM_WORDS];
  logic [`RV_XLEN-1:0] dmem [MEM_WORDS];

  // write log, one entry per completed store
  logic [`RV_XLEN-1:0] log_addr [LOG_DEPTH];
  logic [`RV_XLEN-1:0] log_data [LOG_DEPTH];
  int                  log_n;

  // word addressed, both buses answer in the same cycle
  assign idata  = imem[iaddr[9:2]];
  assign drdata = dmem[daddr[9:2]];

  // a held exec cycle repeats the strobe, only the released cycle writes
  always @(posedge clk) begin
    if (dbus_we && !hold) begin
      dmem[daddr[9:2]] <= dwdata;
      if (log_n < LOG_DEPTH) begin
        log_addr[log_n] <= daddr;
        log_data[log_n] <= dwdata;
      end
      log_n <= log_n + 1;
    end
  end

  ////////////////////
  // setup from the testbench
  ////////////////////
  task automatic clear_mem();
    logic [7:0] w;
    for (int i = 0; i < MEM_WORDS; i++) begin
      w = i[7:0];
      // addi x0, x0, 0
      imem[i] = 32'h0000_0013;
      dmem[i] = {8'hd5, w, ~w, 8'h3c};
    end
    log_n = 0;
  endtask

  task automatic put_instr(input int idx, input logic [`RV_XLEN-1:0] word);
    imem[idx] = word;
  endtask

endmodule

`default_nettype wire

/* bench/tb_rv_core.sv */
`default_nettype none
`timescale 1ns/100ps
`include "rv_cfg.svh"

module tb_rv_core import rv_pkg::*; ();

  localparam int N1 = 20;
  localparam int N2 = 11;
  localparam int N3 = 13;
  localparam int N4 = 4;
  localparam int MAX_HOLD = 32;
  // five runs with reset and tail cycles, test 1 program runs twice
  localparam int RUN_CYCLES = 3 * (N1 + N2 + N3 + N4 + N1) + 5 * 7 + MAX_HOLD;
  localparam int CYCLE_LIMIT = RUN_CYCLES * 3 / 2;

  typedef struct packed {
    logic [`RV_XLEN-1:0] iaddr;
    logic                en_iaddr;
    logic [`RV_XLEN-1:0] daddr;
    logic [`RV_XLEN-1:0] dwdata;
    logic                dbus_we;
    logic                dbus_re;
  } bus_snap_t;

  logic                clk, rst, hold;
  logic [`RV_XLEN-1:0] iaddr, idata, daddr, dwdata, drdata;
  logic                en_iaddr, dbus_we, dbus_re;
  bus_snap_t           bus_now, bus_prev;

  int                  errors, checks, seed, cycles;
  bit                  hold_plan[$];
  logic [`RV_XLEN-1:0] exp_addr[$], exp_data[$], fetch_pc[$];

  // run monitor state
  bit running, prev_en, prev_hold;
  int sample_cyc, ucyc, rise_ucyc, rise_cyc, en_cnt, we_cnt, re_cnt;

  rv_core DUT (
    .clk      (clk),
    .rst      (rst),
    .hold     (hold),
    .iaddr    (iaddr),
    .en_iaddr (en_iaddr),
    .idata    (idata),
    .daddr    (daddr),
    .dwdata   (dwdata),
    .dbus_we  (dbus_we),
    .dbus_re  (dbus_re),
    .drdata   (drdata)
  );

  tb_memory mem (
    .clk     (clk),
    .hold    (hold),
    .iaddr   (iaddr),
    .idata   (idata),
    .daddr   (daddr),
    .dwdata  (dwdata),
    .dbus_we (dbus_we),
    .drdata  (drdata)
  );

  assign bus_now = {iaddr, en_iaddr, daddr, dwdata, dbus_we, dbus_re};

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////
  // instruction encoding
  ////////////////////
  function automatic logic [31:0] i_form(input int imm, input int rs1, input logic [2:0] f3,
                                         input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return i_form(imm, rs1, 3'b000, rd, OP_ALUI);
  endfunction

  function automatic logic [31:0] lw(input int rd, input int imm, input int rs1);
    return i_form(imm, rs1, 3'b010, rd, OP_LOAD);
  endfunction

  function automatic logic [31:0] jalr(input int rd, input int rs1, input int imm);
    return i_form(imm, rs1, 3'b000, rd, OP_JALR);
  endfunction

  function automatic logic [31:0] rr(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_ALU};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int imm, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
  endfunction

  function automatic logic [31:0] upper(input int imm20, input int rd, input logic [6:0] op);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  ////////////////////
  // checking
  ////////////////////
  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic check_log();
    check_word(mem.log_n, exp_addr.size(), "number of logged writes");
    for (int i = 0; i < exp_addr.size() && i < mem.log_n; i++) begin
      check_word(mem.log_addr[i], exp_addr[i], "write address");
      check_word(mem.log_data[i], exp_data[i], "write data");
    end
  endtask

  // the run must stop exactly at the fetch that follows the last instruction
  task automatic check_end(input int n_instr, input logic [31:0] final_pc);
    check_word(fetch_pc.size(), n_instr + 1, "number of fetches");
    check_word(rise_cyc, hold_plan.size(), "cycle of the last fetch");
    if (fetch_pc.size() > 0) begin
      check_word(fetch_pc[fetch_pc.size() - 1], final_pc, "last fetch address");
    end
  endtask

  // samples at the falling edge, where every output is settled
  always @(negedge clk) begin
    if (running) begin
      if (prev_hold) begin
        checks++;
        assert (bus_now === bus_prev) else begin
          errors++;
          $display("FAILED %0t: bus outputs changed under hold", $time);
        end
      end
      if (en_iaddr && !prev_en) begin
        fetch_pc.push_back(iaddr);
        rise_ucyc = ucyc;
        rise_cyc  = sample_cyc;
      end
      // strobes belong to the third cycle of the instruction
      if ((dbus_we || dbus_re) && !hold) begin
        checks++;
        assert (ucyc - rise_ucyc == 2) else begin
          errors++;
          $display("FAILED %0t: data strobe %0d cycles after fetch, expected 2",
                   $time, ucyc - rise_ucyc);
        end
      end
      if (dbus_we) we_cnt++;
      if (dbus_re) re_cnt++;
      if (en_iaddr && !hold) en_cnt++;
      bus_prev  = bus_now;
      prev_en   = en_iaddr;
      prev_hold = hold;
      if (!hold) ucyc++;
      sample_cyc++;
    end
  end

  ////////////////////
  // run control
  ////////////////////
  task automatic apply_reset();
    @(posedge clk);
    rst  <= 1'b0;
    hold <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      checks++;
      assert (!en_iaddr && !dbus_we && !dbus_re) else begin
        errors++;
        $display("FAILED %0t: en_iaddr or a data strobe is high in reset", $time);
      end
      @(posedge clk);
    end
  endtask

  // one unheld cycle to leave the null phase, then three per instruction
  task automatic build_plan(input int n_instr, input bit with_hold);
    int r;
    int runs;
    hold_plan.delete();
    runs = 0;
    for (int i = 0; i < 3 * n_instr + 1; i++) begin
      if (with_hold) begin
        r = $random(seed);
        if (runs < 8 && r[2:0] == 3'd0) begin
          for (int k = 0; k <= r[5:4]; k++) begin
            hold_plan.push_back(1'b1);
          end
          runs++;
        end
      end
      hold_plan.push_back(1'b0);
    end
  endtask

  // starts on the edge that ends reset
  task automatic run_prog();
    int len;
    len = hold_plan.size();
    fetch_pc.delete();
    sample_cyc = 0;
    ucyc       = 0;
    rise_ucyc  = 0;
    rise_cyc   = -1;
    en_cnt     = 0;
    we_cnt     = 0;
    re_cnt     = 0;
    prev_en    = 1'b0;
    prev_hold  = 1'b0;
    rst <= 1'b1;
    running = 1'b1;
    for (int c = 0; c <= len; c++) begin
      if (c > 0) @(posedge clk);
      hold <= (c < len) ? hold_plan[c] : 1'b0;
      @(negedge clk);
    end
    @(posedge clk);
    running = 1'b0;
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic alu_program();
    logic [31:0] v [10];
    mem.clear_mem();
    exp_addr.delete();
    exp_data.delete();
    mem.put_instr(0, addi(1, 0, 100));
    mem.put_instr(1, addi(2, 0, -1000));
    mem.put_instr(2, addi(8, 0, 3));
    mem.put_instr(3, rr(7'h00, 3'b000, 3, 1, 2));
    mem.put_instr(4, rr(7'h20, 3'b000, 4, 1, 2));
    mem.put_instr(5, rr(7'h00, 3'b100, 5, 1, 2));
    mem.put_instr(6, rr(7'h00, 3'b010, 6, 2, 1));
    mem.put_instr(7, rr(7'h20, 3'b101, 7, 2, 8));
    mem.put_instr(8, upper(20'habcde, 9, OP_LUI));
    mem.put_instr(9, addi(0, 1, 55));
    for (int k = 0; k < 10; k++) begin
      mem.put_instr(10 + k, sw(k, 4 * k, 0));
    end
    v[0] = 32'd0;
    v[1] = 32'd100;
    v[2] = -32'sd1000;
    v[8] = 32'd3;
    v[3] = v[1] + v[2];
    v[4] = v[1] - v[2];
    v[5] = v[1] ^ v[2];
    v[6] = ($signed(v[2]) < $signed(v[1])) ? 32'd1 : 32'd0;
    v[7] = $signed(v[2]) >>> v[8][4:0];
    v[9] = 32'habcde << 12;
    for (int k = 0; k < 10; k++) begin
      expect_write(4 * k, v[k]);
    end
  endtask

  task automatic alu_test();
    apply_reset();
    alu_program();
    build_plan(N1, 1'b0);
    run_prog();
    check_log();
    check_end(N1, 4 * N1);
  endtask

  task automatic load_store_test();
    logic [31:0] base, a, b, fill;
    apply_reset();
    mem.clear_mem();
    exp_addr.delete();
    exp_data.delete();
    mem.put_instr(0, addi(1, 0, 32'h40));
    mem.put_instr(1, addi(2, 0, 32'h123));
    mem.put_instr(2, addi(3, 0, -2));
    mem.put_instr(3, sw(2, 8, 1));
    mem.put_instr(4, sw(3, -4, 1));
    mem.put_instr(5, lw(4, 8, 1));
    mem.put_instr(6, lw(5, -4, 1));
    mem.put_instr(7, rr(7'h00, 3'b000, 6, 4, 5));
    mem.put_instr(8, sw(6, 16, 1));
    mem.put_instr(9, lw(7, 32'h100, 0));
    mem.put_instr(10, sw(7, 12, 1));
    base = 32'h40;
    a    = 32'h123;
    b    = -32'sd2;
    fill = mem.dmem[32'h100 >> 2];
    expect_write(base + 8, a);
    expect_write(base - 4, b);
    expect_write(base + 16, a + b);
    expect_write(base + 12, fill);
    build_plan(N2, 1'b0);
    run_prog();
    check_log();
    check_word(re_cnt, 3, "cycles with dbus_re high");
    check_end(N2, 4 * N2);
  endtask

  task automatic branch_jump_test();
    int path [14];
    apply_reset();
    mem.clear_mem();
    exp_addr.delete();
    exp_data.delete();
    mem.put_instr(0, addi(1, 0, 5));
    mem.put_instr(1, addi(2, 0, 5));
    mem.put_instr(2, branch(3'b000, 1, 2, 8));
    mem.put_instr(3, addi(10, 0, 1));
    mem.put_instr(4, branch(3'b000, 1, 0, 8));
    mem.put_instr(5, branch(3'b001, 1, 0, 8));
    mem.put_instr(6, addi(10, 0, 2));
    mem.put_instr(7, jal(3, 12));
    mem.put_instr(8, addi(10, 0, 3));
    mem.put_instr(9, addi(10, 0, 4));
    mem.put_instr(10, addi(5, 0, 61));
    // 61 + 4 is odd, the jump target drops bit 0
    mem.put_instr(11, jalr(4, 5, 4));
    mem.put_instr(16, upper(20'h12345, 6, OP_AUIPC));
    mem.put_instr(17, sw(3, 32'h80, 0));
    mem.put_instr(18, sw(4, 32'h84, 0));
    mem.put_instr(19, sw(6, 32'h88, 0));
    mem.put_instr(20, sw(10, 32'h8c, 0));
    path = '{0, 1, 2, 4, 5, 7, 10, 11, 16, 17, 18, 19, 20, 21};
    expect_write(32'h80, 4 * 7 + 4);
    expect_write(32'h84, 4 * 11 + 4);
    expect_write(32'h88, 4 * 16 + (32'h12345 << 12));
    // every write to x10 sits on a skipped path
    expect_write(32'h8c, 32'd0);
    build_plan(N3, 1'b0);
    run_prog();
    for (int i = 0; i < 14 && i < fetch_pc.size(); i++) begin
      check_word(fetch_pc[i], 4 * path[i], "fetch address");
    end
    check_log();
    check_end(N3, 4 * 21);
  endtask

  task automatic phase_timing_test();
    apply_reset();
    mem.clear_mem();
    exp_addr.delete();
    exp_data.delete();
    mem.put_instr(0, addi(1, 0, 9));
    mem.put_instr(1, sw(1, 32, 0));
    mem.put_instr(2, lw(2, 32, 0));
    mem.put_instr(3, sw(2, 36, 0));
    expect_write(32, 9);
    expect_write(36, 9);
    build_plan(N4, 1'b0);
    run_prog();
    // two of three per instruction, plus the closing fetch
    check_word(en_cnt, 2 * N4 + 1, "cycles with en_iaddr high");
    check_word(we_cnt, 2, "cycles with dbus_we high");
    check_word(re_cnt, 1, "cycles with dbus_re high");
    check_log();
    check_end(N4, 4 * N4);
  endtask

  task automatic hold_test();
    apply_reset();
    alu_program();
    build_plan(N1, 1'b1);
    checks++;
    assert (hold_plan.size() > 3 * N1 + 1) else begin
      errors++;
      $display("the random hold plan came out without any hold cycle");
    end
    run_prog();
    check_log();
    check_end(N1, 4 * N1);
  endtask

  initial begin
    rst     = 1'b0;
    hold    = 1'b0;
    seed    = 60;
    errors  = 0;
    checks  = 0;
    running = 1'b0;
    alu_test();
    load_store_test();
    branch_jump_test();
    phase_timing_test();
    hold_test();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/control_unit.sv
verilog/datapath.sv
verilog/rv_core.sv
bench/tb_memory.sv
bench/tb_rv_core.sv
